// File: build.f
src/link_pkg.sv
src/block_frame_if.sv
src/msg_block_counter.sv
src/enqueue_register.sv
src/dequeue_shift_register.sv
src/link_framer_top.sv
testbench/tb_clk_gen.sv
testbench/tb_link_framer.sv

// File: run_sim.sh
#!/bin/sh
# Compiles the link framer testbench with Verilator and runs it.
# A $fatal in the testbench gives a nonzero exit status.
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -Wno-fatal \
  --top-module tb_link_framer -f build.f -o sim_link_framer
./obj_dir/sim_link_framer

// File: src/block_frame_if.sv
/*
 * Frame channel between the enqueue and dequeue halves of the link
 */

`timescale 1ns/1ps

interface block_frame_if import link_pkg::*; #(
  parameter int ClkDiv = link_pkg::ClkDiv
) ();

  // Valid/ready handshake, a transfer on every edge where both are high
  logic                          frame_valid;
  logic                          frame_ready;
  // Blocks from index 0 upward, unused blocks read as zero
  data_block_t [ClkDiv-1:0]      frame_blocks;
  block_cnt_t                    used_blocks;

  modport source (output frame_valid, frame_blocks, used_blocks, input frame_ready);
  modport sink (input frame_valid, frame_blocks, used_blocks, output frame_ready);

endinterface

// File: src/dequeue_shift_register.sv
/*
 * Receive side of the link. Splits a frame at its control bits and
 * hands out one message per output transfer
 */

`timescale 1ns/1ps

module dequeue_shift_register import link_pkg::*; #(
  parameter int ClkDiv = link_pkg::ClkDiv
) (
  input  logic        clk_i,
  input  logic        rst_i,
  block_frame_if.sink frame_i,
  output logic        valid_o,
  input  logic        ready_i,
  output byte_data_t  data_o,
  output strb_t       strb_o
);

  data_block_t [ClkDiv-1:0] blocks_q;
  data_block_t [ClkDiv-1:0] shifted;
  block_cnt_t               rem_q;
  block_cnt_t               msg_len;
  logic                     frame_take;
  logic                     out_take;

  // A new frame is only taken once every message of the last one is gone
  assign frame_i.frame_ready = (rem_q == '0);
  assign valid_o             = (rem_q != '0);
  assign frame_take          = frame_i.frame_valid && frame_i.frame_ready;
  assign out_take            = valid_o && ready_i;

  ////////////////////////////////////////////////////////////////////////////
  // Message boundary

  // Block 0 always starts a message, the next set control bit starts the
  // one after it. Without one, the message runs to the end of the frame
  always_comb begin : find_boundary
    logic found;
    found   = 1'b0;
    msg_len = rem_q;
    for (int i = 1; i < ClkDiv; i++) begin
      if (!found && i < int'(rem_q) && blocks_q[i].ctrl) begin
        msg_len = block_cnt_t'(i);
        found   = 1'b1;
      end
    end
  end

  // Each block gives back one byte and one strobe bit
  always_comb begin : build_message
    data_o = '0;
    strb_o = '0;
    for (int j = 0; j < NumBytes; j++) begin
      if (j < ClkDiv && j < int'(msg_len)) begin
        data_o[8*j +: 8] = blocks_q[j].data;
        strb_o[j]        = 1'b1;
      end
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Shift register

  // Drop the message just sent, the next one moves down to block 0
  always_comb begin : shift_blocks
    for (int i = 0; i < ClkDiv; i++) begin
      if (i + int'(msg_len) < ClkDiv) begin
        shifted[i] = blocks_q[i + int'(msg_len)];
      end else begin
        shifted[i] = '0;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (frame_take) begin
      blocks_q <= frame_i.frame_blocks;
    end else if (out_take) begin
      blocks_q <= shifted;
    end
  end

  // Blocks of the current frame not yet handed out
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      rem_q <= '0;
    end else if (frame_take) begin
      rem_q <= frame_i.used_blocks;
    end else if (out_take) begin
      rem_q <= rem_q - msg_len;
    end
  end

  // The enqueue side must open every frame with a message start
  a_frame_starts_msg : assert property (@(posedge clk_i) disable iff (rst_i)
    frame_take |-> frame_i.frame_blocks[0].ctrl);

endmodule

// File: src/enqueue_register.sv
/*
 * Transmit side of the link. Packs messages into one frame of blocks,
 * stamps the start-of-message control bits and spaces frames ClkDiv apart
 */

`timescale 1ns/1ps

module enqueue_register import link_pkg::*; #(
  parameter int ClkDiv      = link_pkg::ClkDiv,
  parameter bit AllowVarLen = 1'b1
) (
  input  logic          clk_i,
  input  logic          rst_i,
  input  logic          valid_i,
  output logic          ready_o,
  input  byte_data_t    data_i,
  input  strb_t         strb_i,
  block_frame_if.source frame_o
);

  // Width of the hold counter, at least one bit
  localparam int HoldW = (ClkDiv > 1) ? $clog2(ClkDiv) : 1;
  localparam int CntW  = $bits(block_cnt_t);

  enq_state_e               state_q, state_d;
  block_cnt_t               occ_q, occ_d;
  block_cnt_t               req_blocks;
  logic [CntW:0]            fill_sum;
  logic [HoldW-1:0]         hold_q;
  logic                     started_q;
  logic                     accept;
  logic                     frame_done;
  logic [ClkDiv-1:0]        place_en;
  data_block_t [ClkDiv-1:0] place_blk;
  data_block_t [ClkDiv-1:0] blocks_q;

  msg_block_counter #(
    .AllowVarLen ( AllowVarLen )
  ) u_block_counter (
    .strb_i       ( strb_i     ),
    .req_blocks_o ( req_blocks )
  );

  ////////////////////////////////////////////////////////////////////////////
  // Handshakes

  // One bit wider than the count so that a frame overrun is visible
  assign fill_sum   = occ_q + req_blocks;
  assign accept     = valid_i && ready_o;
  assign frame_done = frame_o.frame_valid && frame_o.frame_ready;

  // An empty frame takes anything once out of reset.
  // While collecting, a message joins only if it fits and the link is
  // still busy with the previous frame, so packing costs no time
  always_comb begin : input_ready
    ready_o = 1'b0;
    case (state_q)
      EnqIdle:    ready_o = started_q;
      EnqCollect: ready_o = (hold_q != '0) && (fill_sum <= ClkDiv);
      default:    ready_o = 1'b0;
    endcase
  end

  ////////////////////////////////////////////////////////////////////////////
  // Frame state and occupied blocks

  always_comb begin : next_state
    state_d = state_q;
    occ_d   = occ_q;
    case (state_q)
      EnqIdle: begin
        // An empty strobe carries nothing and is dropped
        if (accept && req_blocks != '0) begin
          state_d = EnqCollect;
          occ_d   = req_blocks;
        end
      end
      EnqCollect: begin
        if (accept) begin
          occ_d = occ_q + req_blocks;
        end
        // The link is free again, so the frame goes out now
        if (hold_q == '0) begin
          state_d = EnqHold;
        end
      end
      EnqHold: begin
        if (frame_done) begin
          state_d = EnqIdle;
          occ_d   = '0;
        end
      end
      default: begin
        state_d = EnqIdle;
        occ_d   = '0;
      end
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      state_q   <= EnqIdle;
      occ_q     <= '0;
      started_q <= 1'b0;
    end else begin
      state_q   <= state_d;
      occ_q     <= occ_d;
      started_q <= 1'b1;
    end
  end

  // Models the slow link. Reloaded on every frame transfer and counts
  // down, a new frame may only be offered once it reaches zero
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      hold_q <= '0;
    end else if (frame_done) begin
      hold_q <= HoldW'(ClkDiv - 1);
    end else if (hold_q != '0) begin
      hold_q <= hold_q - 1'b1;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Block placement

  // Byte k of the message lands in block occ_q + k.
  // Only its first block gets the control bit
  always_comb begin : place_blocks
    int k;
    for (int i = 0; i < ClkDiv; i++) begin
      k = i - int'(occ_q);
      place_en[i]       = (k >= 0) && (i < int'(fill_sum));
      place_blk[i].ctrl = (k == 0);
      place_blk[i].data = '0;
      if (k >= 0 && k < NumBytes) begin
        place_blk[i].data = data_i[8*k +: 8];
      end
    end
  end

  always_ff @(posedge clk_i) begin
    for (int i = 0; i < ClkDiv; i++) begin
      if (accept && place_en[i]) begin
        blocks_q[i] <= place_blk[i];
      end
    end
  end

  // Blocks above the used count still hold an older frame, zero them out
  always_comb begin : frame_out
    for (int i = 0; i < ClkDiv; i++) begin
      frame_o.frame_blocks[i] = (i < int'(occ_q)) ? blocks_q[i] : '0;
    end
  end

  assign frame_o.frame_valid = (state_q == EnqHold);
  assign frame_o.used_blocks = occ_q;

  ////////////////////////////////////////////////////////////////////////////
  // Checks

  a_occ_in_range : assert property (@(posedge clk_i) disable iff (rst_i)
    occ_q <= ClkDiv);

  // The dequeue side may sample the frame on any cycle of a stall
  a_frame_stable : assert property (@(posedge clk_i) disable iff (rst_i)
    frame_o.frame_valid && !frame_o.frame_ready |=> $stable(frame_o.frame_blocks));

endmodule

// File: src/link_framer_top.sv
/*
 * Loopback of the link framing, enqueue side straight into dequeue side
 */

`timescale 1ns/1ps

module link_framer_top import link_pkg::*; #(
  parameter int ClkDiv      = link_pkg::ClkDiv,
  parameter bit AllowVarLen = 1'b1
) (
  input  logic       clk_i,
  input  logic       rst_i,
  // Message stream into the transmitter
  input  logic       in_valid_i,
  output logic       in_ready_o,
  input  byte_data_t in_data_i,
  input  strb_t      in_strb_i,
  // Message stream out of the receiver
  output logic       out_valid_o,
  input  logic       out_ready_i,
  output byte_data_t out_data_o,
  output strb_t      out_strb_o
);

  // Stands in for the physical link between the two halves
  block_frame_if #(.ClkDiv(ClkDiv)) frame_link ();

  enqueue_register #(
    .ClkDiv      ( ClkDiv      ),
    .AllowVarLen ( AllowVarLen )
  ) u_enqueue (
    .clk_i   ( clk_i             ),
    .rst_i   ( rst_i             ),
    .valid_i ( in_valid_i        ),
    .ready_o ( in_ready_o        ),
    .data_i  ( in_data_i         ),
    .strb_i  ( in_strb_i         ),
    .frame_o ( frame_link.source )
  );

  dequeue_shift_register #(
    .ClkDiv ( ClkDiv )
  ) u_dequeue (
    .clk_i   ( clk_i           ),
    .rst_i   ( rst_i           ),
    .frame_i ( frame_link.sink ),
    .valid_o ( out_valid_o     ),
    .ready_i ( out_ready_i     ),
    .data_o  ( out_data_o      ),
    .strb_o  ( out_strb_o      )
  );

endmodule

// File: src/link_pkg.sv
/*
 * Shared sizes and types of the serial link framing:
 * message word and strobe, nine-bit block, block count and enqueue states
 */

package link_pkg;

  // Bytes carried by one message word on the input and output streams
  localparam int NumBytes = 4;

  // One data byte plus the control bit that marks a message start
  localparam int BlockSize = 9;

  // Default cycles a frame occupies the link, which is also the blocks per frame
  localparam int ClkDiv = 4;

  // Message payload, byte 0 in the low bits
  typedef logic [NumBytes*8-1:0] byte_data_t;

  // Message strobe. Only a run of low set bits is a legal message size
  typedef logic [NumBytes-1:0] strb_t;

  // The control bit sits at bit 0 of every block, the byte above it
  typedef struct packed {
    logic [BlockSize-2:0] data;
    logic                 ctrl;
  } data_block_t;

  // Counts blocks from 0 up to a full frame
  typedef logic [$clog2(ClkDiv+1)-1:0] block_cnt_t;

  // Frame empty, frame being filled, frame offered to the link
  typedef enum logic [1:0] {
    EnqIdle,
    EnqCollect,
    EnqHold
  } enq_state_e;

endpackage

// File: src/msg_block_counter.sv
/*
 * Block count for one message, taken from the run of low set strobe bits
 */

`timescale 1ns/1ps

module msg_block_counter import link_pkg::*; #(
  parameter bit AllowVarLen = 1'b1
) (
  input  strb_t      strb_i,
  output block_cnt_t req_blocks_o
);

  if (AllowVarLen) begin : gen_var_len
    block_cnt_t trailing_ones;

    // Priority scan from byte 0, the first clear bit ends the run
    always_comb begin : scan_strobe
      logic gap;
      gap = 1'b0;
      trailing_ones = '0;
      for (int i = 0; i < NumBytes; i++) begin
        if (!strb_i[i]) begin
          gap = 1'b1;
        end else if (!gap) begin
          trailing_ones = trailing_ones + 1'b1;
        end
      end
    end

    // A full strobe always fills the frame, one byte per block
    assign req_blocks_o = (&strb_i) ? block_cnt_t'(ClkDiv) : trailing_ones;
  end else begin : gen_full_len
    // Every message is treated as the largest one
    assign req_blocks_o = block_cnt_t'(ClkDiv);
  end

endmodule

// File: testbench/tb_clk_gen.sv
/*
 * Testbench clock of 40 ns and a reset held for the first 10 cycles
 */

`timescale 1ns/1ps

module tb_clk_gen (
  output logic clk_o,
  output logic rst_o
);

  initial begin
    clk_o = 1'b0;
    forever begin
      #20 clk_o = ~clk_o;
    end
  end

  // Synchronous reset, released on a falling edge like every other input
  initial begin
    rst_o = 1'b1;
    repeat (10) @(posedge clk_o);
    @(negedge clk_o);
    rst_o = 1'b0;
  end

endmodule

// File: testbench/tb_link_framer.sv
/*
 * Directed loopback tests of the link framer covering the reset state,
 * single messages, packed bursts, full messages and output back-pressure
 */

`timescale 1ns/1ps

module tb_link_framer import link_pkg::*; ();

  logic       clk;
  logic       rst;
  logic       in_valid;
  logic       in_ready;
  byte_data_t in_data;
  strb_t      in_strb;
  logic       out_valid;
  logic       out_ready;
  byte_data_t out_data;
  strb_t      out_strb;

  // Messages accepted by the DUT that have not reached the output yet
  byte_data_t exp_data_q[$];
  strb_t      exp_strb_q[$];
  // One out_ready value per cycle, the output stays ready once it runs empty
  bit         ready_plan[$];

  tb_clk_gen u_clk_gen (
    .clk_o ( clk ),
    .rst_o ( rst )
  );

  link_framer_top u_dut (
    .clk_i       ( clk       ),
    .rst_i       ( rst       ),
    .in_valid_i  ( in_valid  ),
    .in_ready_o  ( in_ready  ),
    .in_data_i   ( in_data   ),
    .in_strb_i   ( in_strb   ),
    .out_valid_o ( out_valid ),
    .out_ready_i ( out_ready ),
    .out_data_o  ( out_data  ),
    .out_strb_o  ( out_strb  )
  );

  ////////////////////////////////////////////////////////////////////////////
  // Checks

  task automatic abort_run(input string what);
    $display("%s", what);
    $display("Some tests failed");
    $fatal(1, "Simulation stopped at the first error");
  endtask

  task automatic compare_flag(input string name, input logic exp, input logic got);
    if (got !== exp) begin
      abort_run($sformatf("FAIL %s expected %h got %h", name, exp, got));
    end
  endtask

  task automatic compare_strb(input string name, input strb_t exp, input strb_t got);
    if (got !== exp) begin
      abort_run($sformatf("FAIL %s expected %h got %h", name, exp, got));
    end
  endtask

  // Only the bytes marked by the expected strobe carry meaning
  task automatic compare_data(input string name, input byte_data_t exp,
                              input byte_data_t got, input strb_t strb);
    byte_data_t mask;
    for (int i = 0; i < NumBytes; i++) begin
      mask[8*i +: 8] = {8{strb[i]}};
    end
    if ((got & mask) !== (exp & mask)) begin
      abort_run($sformatf("FAIL %s expected %h got %h", name, exp & mask, got & mask));
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Stimulus

  // Holds the message on the input until in_ready_o is seen, then queues it
  task automatic send_msg(input byte_data_t data, input strb_t strb);
    int waited;
    waited = 0;
    @(negedge clk);
    in_valid = 1'b1;
    in_data  = data;
    in_strb  = strb;
    #1;
    while (!in_ready) begin
      if (waited == 50) begin
        abort_run("in_ready_o stayed low and a message was never accepted");
      end else begin
        waited++;
        @(negedge clk);
        #1;
      end
    end
    exp_data_q.push_back(data);
    exp_strb_q.push_back(strb);
  endtask

  task automatic release_input();
    @(negedge clk);
    in_valid = 1'b0;
    in_data  = '0;
    in_strb  = '0;
  endtask

  task automatic wait_drained(input int limit);
    int waited;
    waited = 0;
    while (exp_data_q.size() != 0) begin
      if (waited == limit) begin
        abort_run("Timed out waiting for the sent messages to come back");
      end else begin
        waited++;
        @(posedge clk);
      end
    end
  endtask

  // Drives out_ready_i on the falling edge, then checks what the DUT
  // presents and whether a stalled message stayed put
  initial begin : watch_output
    logic       stalled;
    byte_data_t held_data;
    strb_t      held_strb;
    stalled   = 1'b0;
    held_data = '0;
    held_strb = '0;
    out_ready = 1'b0;
    forever begin
      @(negedge clk);
      if (rst) begin
        out_ready = 1'b0;
      end else if (ready_plan.size() != 0) begin
        out_ready = ready_plan.pop_front();
      end else begin
        out_ready = 1'b1;
      end
      #1;
      if (stalled) begin
        compare_flag("out_valid_o", 1'b1, out_valid);
        compare_data("out_data_o", held_data, out_data, held_strb);
        compare_strb("out_strb_o", held_strb, out_strb);
      end
      stalled   = out_valid && !out_ready;
      held_data = out_data;
      held_strb = out_strb;
      if (out_valid && out_ready) begin
        if (exp_data_q.size() == 0) begin
          abort_run("The DUT sent a message that was never put in");
        end else begin
          compare_data("out_data_o", exp_data_q[0], out_data, exp_strb_q[0]);
          compare_strb("out_strb_o", exp_strb_q[0], out_strb);
          void'(exp_data_q.pop_front());
          void'(exp_strb_q.pop_front());
        end
      end
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Tests

  task automatic after_reset();
    int waited;
    waited = 0;
    @(negedge clk);
    #1;
    while (rst) begin
      if (waited == 20) begin
        abort_run("Reset was never released");
      end else begin
        waited++;
        @(negedge clk);
        #1;
      end
    end
    compare_flag("out_valid_o", 1'b0, out_valid);
    // The transmitter opens one cycle after reset
    waited = 0;
    while (!in_ready) begin
      if (waited == 5) begin
        abort_run("in_ready_o did not rise after reset");
      end else begin
        waited++;
        @(negedge clk);
        #1;
      end
    end
  endtask

  task automatic each_length();
    strb_t strb;
    for (int len = 1; len <= NumBytes; len++) begin
      strb = strb_t'((1 << len) - 1);
      send_msg(byte_data_t'(32'hc3a5_5a17 + len * 32'h0101_0101), strb);
      release_input();
      wait_drained(40);
    end
  endtask

  // Short messages let several of them share one frame
  task automatic packed_burst();
    byte_data_t data_list[16];
    strb_t      strb_list[16];
    for (int i = 0; i < 16; i++) begin
      data_list[i] = $urandom();
      strb_list[i] = ($urandom_range(0, 1) == 0) ? 4'b0001 : 4'b0011;
    end
    for (int i = 0; i < 16; i++) begin
      send_msg(data_list[i], strb_list[i]);
    end
    release_input();
    wait_drained(200);
  endtask

  task automatic full_messages();
    for (int i = 0; i < 5; i++) begin
      send_msg(byte_data_t'(32'h1020_3040 + i * 32'h0101_0101), 4'b1111);
    end
    release_input();
    wait_drained(100);
  endtask

  // The whole stall pattern is drawn up front before any message is sent
  task automatic output_stalls();
    int         count;
    byte_data_t data;
    strb_t      strb;
    count = $urandom_range(12, 30);
    while (ready_plan.size() < 300) begin
      repeat ($urandom_range(1, 4)) ready_plan.push_back(1'b1);
      repeat ($urandom_range(1, 8)) ready_plan.push_back(1'b0);
    end
    for (int i = 0; i < count; i++) begin
      strb = strb_t'((1 << $urandom_range(1, NumBytes)) - 1);
      data = $urandom();
      send_msg(data, strb);
    end
    release_input();
    wait_drained(2000);
    // Nothing may come out after the last message of the burst
    @(negedge clk);
    #1;
    compare_flag("out_valid_o", 1'b0, out_valid);
    ready_plan.delete();
  endtask

  initial begin : run_tests
    void'($urandom(32'h8f51));
    in_valid = 1'b0;
    in_data  = '0;
    in_strb  = '0;
    after_reset();
    each_length();
    packed_burst();
    full_messages();
    output_stalls();
    $display("All tests passed");
    $finish;
  end

endmodule
